//--- rtl/tl2umi_macros.svh
`ifndef TL2UMI_MACROS_SVH
`define TL2UMI_MACROS_SVH

// UMI packet widths
`define TL2UMI_CW 32
`define TL2UMI_AW 64
`define TL2UMI_DW 64

// Chip id carried in the source address
`define TL2UMI_IDW 16

// TileLink-UH channel widths
`define TL2UMI_TL_AW 56
`define TL2UMI_SRCW 5

// Bytes per TileLink beat
`define TL2UMI_MASKW 8

// Outgoing request buffering
`define TL2UMI_REQ_DEPTH 2

`endif

//--- rtl/tl2umi_pkg.sv
`include "tl2umi_macros.svh"

package tl2umi_pkg;

    typedef enum logic [2:0] {
        TL_A_PUT_FULL    = 3'd0,
        TL_A_PUT_PARTIAL = 3'd1,
        TL_A_GET         = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        TL_D_ACCESS_ACK      = 3'd0,
        TL_D_ACCESS_ACK_DATA = 3'd1
    } tl_d_opcode_e;

    // Only the opcodes this bridge issues or consumes
    typedef enum logic [4:0] {
        UMI_REQ_READ   = 5'd1,
        UMI_RESP_READ  = 5'd2,
        UMI_REQ_WRITE  = 5'd3,
        UMI_RESP_WRITE = 5'd4
    } umi_opcode_e;

    typedef logic [7:0]                   byte_count_t;
    typedef logic [3:0]                   lane_t;
    typedef logic [`TL2UMI_IDW-1:0]       chipid_t;
    typedef logic [`TL2UMI_TL_AW-1:0]     tl_addr_t;
    typedef logic [`TL2UMI_SRCW-1:0]      tl_source_t;
    typedef logic [`TL2UMI_AW-1:0]        umi_addr_t;
    typedef logic [`TL2UMI_DW-1:0]        umi_data_t;

    typedef struct packed {
        logic [4:0]  hostid;
        logic [1:0]  err;
        logic        ex;
        logic        eof;
        logic        eom;
        logic [1:0]  prot;
        logic [3:0]  qos;
        byte_count_t len;
        logic [2:0]  size;
        umi_opcode_e opcode;
    } umi_cmd_t;

    // Request tag, echoed back by the device as the response dstaddr
    typedef struct packed {
        logic [23:0] chipid;
        logic [7:0]  first_one;
        logic [7:0]  tl_size;
        logic [7:0]  tl_source;
        logic [15:0] zero;
    } umi_srcaddr_t;

    typedef struct packed {
        umi_cmd_t  cmd;
        umi_addr_t dstaddr;
        umi_addr_t srcaddr;
        umi_data_t data;
    } umi_packet_t;

    typedef struct packed {
        tl_a_opcode_e              opcode;
        logic [2:0]                param;
        logic [2:0]                size;
        tl_source_t                source;
        tl_addr_t                  address;
        logic [`TL2UMI_MASKW-1:0]  mask;
        umi_data_t                 data;
    } tl_a_t;

    typedef struct packed {
        tl_d_opcode_e opcode;
        logic [1:0]   param;
        logic [2:0]   size;
        tl_source_t   source;
        logic         sink;
        logic         denied;
        umi_data_t    data;
        logic         corrupt;
    } tl_d_t;

    typedef struct packed {
        lane_t       first_one;
        byte_count_t len;
        umi_addr_t   dstaddr;
        umi_data_t   data;
    } tl_a_conv_t;

endpackage

//--- rtl/tl2umi_mask_convert.sv
`include "tl2umi_macros.svh"

module tl2umi_mask_convert (
    input  tl2umi_pkg::tl_a_t      tl_a,
    output tl2umi_pkg::tl_a_conv_t conv
);
    import tl2umi_pkg::*;

    lane_t       first_one;
    byte_count_t ones;

    // Lowest set mask byte, 8 when the mask is empty
    always_comb begin
        first_one = lane_t'(`TL2UMI_MASKW);
        for (int i = `TL2UMI_MASKW - 1; i >= 0; i--) begin
            if (tl_a.mask[i]) begin
                first_one = lane_t'(i);
            end
        end
    end

    // Population count of the byte mask
    always_comb begin
        ones = '0;
        for (int i = 0; i < `TL2UMI_MASKW; i++) begin
            ones = ones + byte_count_t'(tl_a.mask[i]);
        end
    end

    // UMI len is bytes minus one
    assign conv.len = ones - 8'd1;

    assign conv.first_one = first_one;

    // Low address bits point at the first enabled byte
    assign conv.dstaddr = {
        {(`TL2UMI_AW - `TL2UMI_TL_AW){1'b0}},
        tl_a.address[`TL2UMI_TL_AW-1:3],
        first_one[2:0]
    };

    // Move the enabled bytes down into lane zero
    assign conv.data = tl_a.data >> {first_one, 3'b000};

endmodule

//--- rtl/tl2umi_req_fsm.sv
module tl2umi_req_fsm (
    input  logic                    clk,
    input  logic                    nreset,
    input  tl2umi_pkg::chipid_t     chipid,
    input  logic                    tl_a_valid,
    input  tl2umi_pkg::tl_a_t       tl_a,
    input  tl2umi_pkg::tl_a_conv_t  conv,
    output logic                    tl_a_ready,
    input  logic                    fifo_full,
    output logic                    req_push,
    output tl2umi_pkg::umi_packet_t req_packet,
    output tl2umi_pkg::byte_count_t expect_bytes,
    input  logic                    resp_done
);
    import tl2umi_pkg::*;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_ISSUE,
        REQ_WAIT_ACK
    } req_state_e;

    req_state_e   state;
    logic         accept;
    logic         is_get;
    logic         supported;
    umi_cmd_t     cmd;
    umi_srcaddr_t srcaddr;

    assign tl_a_ready = (state == REQ_IDLE) && !fifo_full;
    assign accept     = tl_a_valid && tl_a_ready;
    assign is_get     = (tl_a.opcode == TL_A_GET);
    assign supported  = is_get ||
                        (tl_a.opcode == TL_A_PUT_FULL) ||
                        (tl_a.opcode == TL_A_PUT_PARTIAL);
    assign req_push   = (state == REQ_ISSUE) && !fifo_full;

    // Single maskless packet, byte sized
    always_comb begin
        cmd = '0;
        cmd.eom = 1'b1;
        if (is_get) begin
            cmd.opcode = UMI_REQ_READ;
            cmd.len = byte_count_t'((9'd1 << tl_a.size) - 9'd1);
        end else begin
            cmd.opcode = UMI_REQ_WRITE;
            cmd.len = conv.len;
        end
    end

    // Fields needed to rebuild the D beat from the response
    always_comb begin
        srcaddr = '0;
        srcaddr.chipid = 24'(chipid);
        srcaddr.first_one = 8'(conv.first_one);
        srcaddr.tl_size = 8'(tl_a.size);
        srcaddr.tl_source = 8'(tl_a.source);
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= REQ_IDLE;
        end else begin
            case (state)
                REQ_IDLE: begin
                    // Unsupported opcodes are taken and forgotten
                    if (accept && supported) begin
                        state <= REQ_ISSUE;
                    end
                end
                REQ_ISSUE: begin
                    if (req_push) begin
                        state <= REQ_WAIT_ACK;
                    end
                end
                REQ_WAIT_ACK: begin
                    if (resp_done) begin
                        state <= REQ_IDLE;
                    end
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && supported) begin
            req_packet.cmd     <= cmd;
            req_packet.dstaddr <= conv.dstaddr;
            req_packet.srcaddr <= srcaddr;
            req_packet.data    <= conv.data;
            if (!is_get) begin
                expect_bytes <= conv.len + 8'd1;
            end
        end
    end

    a_nonzero_mask: assert property (@(posedge clk) disable iff (!nreset)
        (accept && supported) |-> (tl_a.mask != '0));

    // Previous request has drained by the time a new one issues
    a_push_not_full: assert property (@(posedge clk) disable iff (!nreset)
        (state == REQ_ISSUE) |-> !fifo_full);

endmodule

//--- rtl/tl2umi_req_fifo.sv
`include "tl2umi_macros.svh"

module tl2umi_req_fifo (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    push,
    input  tl2umi_pkg::umi_packet_t din,
    output logic                    full,
    input  logic                    pop,
    output tl2umi_pkg::umi_packet_t dout,
    output logic                    valid
);
    import tl2umi_pkg::*;

    localparam int DEPTH = `TL2UMI_REQ_DEPTH;
    localparam int PTRW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW  = $clog2(DEPTH + 1);

    if ($bits(umi_cmd_t) != `TL2UMI_CW) begin : g_cmd_width_check
        $error("UMI command struct does not match the command width");
    end

    umi_packet_t     mem [DEPTH];
    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [CNTW-1:0] count;

    assign full  = (count == CNTW'(DEPTH));
    assign valid = (count != '0);

    // Show-ahead read port
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNTW'(push) - CNTW'(pop);
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (!nreset)
        pop |-> (count != '0));

endmodule

//--- rtl/tl2umi_resp_fsm.sv
module tl2umi_resp_fsm (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    uhost_resp_valid,
    input  tl2umi_pkg::umi_packet_t uhost_resp,
    output logic                    uhost_resp_ready,
    input  tl2umi_pkg::byte_count_t expect_bytes,
    output logic                    tl_d_valid,
    output tl2umi_pkg::tl_d_t       tl_d,
    input  logic                    tl_d_ready,
    output logic                    resp_done
);
    import tl2umi_pkg::*;

    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_WR_COUNT,
        RESP_D_SEND
    } resp_state_e;

    resp_state_e  state;
    umi_srcaddr_t resp_tag;
    logic         resp_fire;
    logic         is_read;
    logic         is_write;
    logic         write_last;
    byte_count_t  resp_bytes;
    byte_count_t  byte_sum;
    byte_count_t  write_total;

    // No new response while a D beat is pending
    assign uhost_resp_ready = (state != RESP_D_SEND);
    assign resp_fire = uhost_resp_valid && uhost_resp_ready;
    assign resp_tag  = umi_srcaddr_t'(uhost_resp.dstaddr);

    assign is_read  = resp_fire && (uhost_resp.cmd.opcode == UMI_RESP_READ);
    assign is_write = resp_fire && (uhost_resp.cmd.opcode == UMI_RESP_WRITE);

    // Bytes acknowledged by this write response
    assign resp_bytes = byte_count_t'((9'(uhost_resp.cmd.len) + 9'd1)
                                      << uhost_resp.cmd.size);
    assign write_total = ((state == RESP_WR_COUNT) ? byte_sum : '0) + resp_bytes;
    assign write_last  = is_write && (write_total == expect_bytes);

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state      <= RESP_IDLE;
            tl_d_valid <= 1'b0;
            resp_done  <= 1'b0;
            byte_sum   <= '0;
        end else begin
            resp_done <= 1'b0;
            case (state)
                RESP_IDLE, RESP_WR_COUNT: begin
                    if (is_read || write_last) begin
                        state      <= RESP_D_SEND;
                        tl_d_valid <= 1'b1;
                    end else if (is_write) begin
                        // Partial write ack, keep counting
                        state    <= RESP_WR_COUNT;
                        byte_sum <= write_total;
                    end
                end
                RESP_D_SEND: begin
                    if (tl_d_ready) begin
                        state      <= RESP_IDLE;
                        tl_d_valid <= 1'b0;
                        resp_done  <= 1'b1;
                    end
                end
                default: state <= RESP_IDLE;
            endcase
        end
    end

    // D beat contents, held until the beat is taken
    always_ff @(posedge clk) begin
        if (is_read || write_last) begin
            if (is_read) begin
                tl_d.opcode <= TL_D_ACCESS_ACK_DATA;
                tl_d.data   <= uhost_resp.data << {resp_tag.first_one[3:0], 3'b000};
            end else begin
                tl_d.opcode <= TL_D_ACCESS_ACK;
                tl_d.data   <= '0;
            end
            tl_d.param   <= '0;
            tl_d.size    <= resp_tag.tl_size[2:0];
            tl_d.source  <= tl_source_t'(resp_tag.tl_source);
            tl_d.sink    <= 1'b0;
            tl_d.denied  <= 1'b0;
            tl_d.corrupt <= 1'b0;
        end
    end

    // Reads must arrive unsplit
    a_read_eom: assert property (@(posedge clk) disable iff (!nreset)
        is_read |-> uhost_resp.cmd.eom);

endmodule

//--- rtl/tl2umi.sv
module tl2umi (
    input  logic                    clk,
    input  logic                    nreset,
    input  tl2umi_pkg::chipid_t     chipid,
    input  logic                    tl_a_valid,
    input  tl2umi_pkg::tl_a_t       tl_a,
    output logic                    tl_a_ready,
    output logic                    tl_d_valid,
    output tl2umi_pkg::tl_d_t       tl_d,
    input  logic                    tl_d_ready,
    output logic                    uhost_req_valid,
    output tl2umi_pkg::umi_packet_t uhost_req,
    input  logic                    uhost_req_ready,
    input  logic                    uhost_resp_valid,
    input  tl2umi_pkg::umi_packet_t uhost_resp,
    output logic                    uhost_resp_ready
);
    import tl2umi_pkg::*;

    tl_a_conv_t  conv;
    umi_packet_t req_packet;
    logic        req_push;
    logic        fifo_full;
    byte_count_t expect_bytes;
    logic        resp_done;

    tl2umi_mask_convert u_mask_convert (
        .tl_a (tl_a),
        .conv (conv)
    );

    tl2umi_req_fsm u_req_fsm (
        .clk          (clk),
        .nreset       (nreset),
        .chipid       (chipid),
        .tl_a_valid   (tl_a_valid),
        .tl_a         (tl_a),
        .conv         (conv),
        .tl_a_ready   (tl_a_ready),
        .fifo_full    (fifo_full),
        .req_push     (req_push),
        .req_packet   (req_packet),
        .expect_bytes (expect_bytes),
        .resp_done    (resp_done)
    );

    tl2umi_req_fifo u_req_fifo (
        .clk    (clk),
        .nreset (nreset),
        .push   (req_push),
        .din    (req_packet),
        .full   (fifo_full),
        .pop    (uhost_req_valid && uhost_req_ready),
        .dout   (uhost_req),
        .valid  (uhost_req_valid)
    );

    tl2umi_resp_fsm u_resp_fsm (
        .clk              (clk),
        .nreset           (nreset),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp       (uhost_resp),
        .uhost_resp_ready (uhost_resp_ready),
        .expect_bytes     (expect_bytes),
        .tl_d_valid       (tl_d_valid),
        .tl_d             (tl_d),
        .tl_d_ready       (tl_d_ready),
        .resp_done        (resp_done)
    );

endmodule

//--- dv/tl2umi_checker.sv
module tl2umi_checker (
    input  logic                    clk,
    input  logic                    nreset,
    input  tl2umi_pkg::chipid_t     chipid,
    input  logic                    tl_a_valid,
    input  tl2umi_pkg::tl_a_t       tl_a,
    input  logic                    tl_a_ready,
    input  logic                    tl_d_valid,
    input  tl2umi_pkg::tl_d_t       tl_d,
    input  logic                    tl_d_ready,
    input  logic                    uhost_req_valid,
    input  tl2umi_pkg::umi_packet_t uhost_req,
    input  logic                    uhost_req_ready,
    input  logic                    uhost_resp_valid,
    input  tl2umi_pkg::umi_packet_t uhost_resp,
    input  logic                    uhost_resp_ready,
    output int                      errors,
    output int                      tests,
    output logic                    drained
);
    timeunit 1ns;
    timeprecision 1ps;
    import tl2umi_pkg::*;

    logic [7:0]  mem [64];
    umi_packet_t exp_req;
    tl_d_t       exp_d;
    logic [7:0]  exp_lanes;
    logic        in_flight;
    logic        req_pending;
    logic        is_write;
    int          acked;
    int          want_bytes;
    int          err_mark;
    logic        req_stall;
    umi_packet_t req_held;
    logic        d_stall;
    tl_d_t       d_held;
    logic        reset_checked;

    assign drained = !in_flight && !req_pending;

    initial begin
        errors = 0;
        tests = 0;
        in_flight = 1'b0;
        req_pending = 1'b0;
        req_stall = 1'b0;
        d_stall = 1'b0;
        reset_checked = 1'b0;
        acked = 0;
        // Same contents the device starts with
        for (int i = 0; i < 64; i++) begin
            mem[i] = 8'(i * 37 + 11);
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic accept_a();
        int           first;
        int           ones;
        logic         get;
        umi_srcaddr_t tag;
        umi_packet_t  p;
        if (in_flight) begin
            report_error("A beat accepted before the previous D beat");
        end
        first = 8;
        ones = 0;
        for (int i = 7; i >= 0; i--) begin
            if (tl_a.mask[i]) begin
                first = i;
            end
        end
        for (int i = 0; i < 8; i++) begin
            ones += int'(tl_a.mask[i]);
        end
        get = (tl_a.opcode == TL_A_GET);
        if (!get && tl_a.opcode != TL_A_PUT_FULL && tl_a.opcode != TL_A_PUT_PARTIAL) begin
            tests++;
            $display("test %0d: opcode %0d dropped", tests, tl_a.opcode);
            return;
        end
        tag = '0;
        tag.chipid = 24'(chipid);
        tag.first_one = 8'(first);
        tag.tl_size = 8'(tl_a.size);
        tag.tl_source = 8'(tl_a.source);
        p = '0;
        p.cmd.eom = 1'b1;
        if (get) begin
            p.cmd.opcode = UMI_REQ_READ;
            p.cmd.len = byte_count_t'((1 << tl_a.size) - 1);
        end else begin
            p.cmd.opcode = UMI_REQ_WRITE;
            p.cmd.len = byte_count_t'(ones - 1);
        end
        p.dstaddr = {8'h00, tl_a.address[55:3], 3'(first)};
        p.srcaddr = tag;
        p.data = tl_a.data >> (8 * first);
        exp_req = p;
        req_pending = 1'b1;

        exp_d = '0;
        exp_d.size = tl_a.size;
        exp_d.source = tl_a.source;
        exp_lanes = tl_a.mask;
        want_bytes = ones;
        acked = 0;
        is_write = !get;
        if (get) begin
            exp_d.opcode = TL_D_ACCESS_ACK_DATA;
            for (int i = 0; i < 8; i++) begin
                exp_d.data[8*i +: 8] = mem[{tl_a.address[5:3], 3'(i)}];
            end
        end else begin
            exp_d.opcode = TL_D_ACCESS_ACK;
            for (int i = 0; i < 8; i++) begin
                if (tl_a.mask[i]) begin
                    mem[{tl_a.address[5:3], 3'(i)}] = tl_a.data[8*i +: 8];
                end
            end
        end
        in_flight = 1'b1;
        err_mark = errors;
    endtask

    task automatic check_req();
        if (!req_pending) begin
            report_error("UMI request with no A beat behind it");
            return;
        end
        req_pending = 1'b0;
        if (uhost_req.cmd != exp_req.cmd) begin
            report_error($sformatf("UMI cmd %h, expected %h", uhost_req.cmd, exp_req.cmd));
        end
        if (uhost_req.dstaddr != exp_req.dstaddr) begin
            report_error($sformatf("UMI dstaddr %h, expected %h",
                                   uhost_req.dstaddr, exp_req.dstaddr));
        end
        if (uhost_req.srcaddr != exp_req.srcaddr) begin
            report_error($sformatf("UMI srcaddr %h, expected %h",
                                   uhost_req.srcaddr, exp_req.srcaddr));
        end
        if (uhost_req.data != exp_req.data) begin
            report_error($sformatf("UMI data %h, expected %h", uhost_req.data, exp_req.data));
        end
    endtask

    task automatic check_d();
        if (!in_flight) begin
            report_error("D beat with no transaction outstanding");
            return;
        end
        in_flight = 1'b0;
        if (tl_d.opcode != exp_d.opcode || tl_d.size != exp_d.size ||
            tl_d.source != exp_d.source) begin
            report_error($sformatf("D opcode/size/source %0d/%0d/%0d, expected %0d/%0d/%0d",
                                   tl_d.opcode, tl_d.size, tl_d.source,
                                   exp_d.opcode, exp_d.size, exp_d.source));
        end
        if (tl_d.param != '0 || tl_d.sink || tl_d.denied || tl_d.corrupt) begin
            report_error("D beat has a non-zero param, sink, denied or corrupt field");
        end
        if (is_write && acked != want_bytes) begin
            report_error($sformatf("AccessAck after %0d of %0d bytes", acked, want_bytes));
        end
        for (int i = 0; i < 8; i++) begin
            if (!is_write && exp_lanes[i] && tl_d.data[8*i +: 8] != exp_d.data[8*i +: 8]) begin
                report_error($sformatf("read lane %0d is %h, expected %h",
                                       i, tl_d.data[8*i +: 8], exp_d.data[8*i +: 8]));
            end
        end
        tests++;
        $display("test %0d: %s size %0d source %0d %s", tests, is_write ? "Put" : "Get",
                 exp_d.size, exp_d.source, (errors == err_mark) ? "ok" : "mismatch");
    endtask

    // Handshakes are judged on the values present at the rising edge
    always @(posedge clk) begin
        if (nreset) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!tl_a_ready || uhost_req_valid || tl_d_valid || !uhost_resp_ready) begin
                    report_error("handshake outputs wrong after reset");
                end
            end
            if (req_stall && (!uhost_req_valid || uhost_req != req_held)) begin
                report_error("UMI request changed while stalled");
            end
            if (d_stall && (!tl_d_valid || tl_d != d_held)) begin
                report_error("D beat changed while stalled");
            end
            if (tl_d_valid && uhost_resp_ready) begin
                report_error("UMI response ready high while a D beat is pending");
            end
            req_stall = uhost_req_valid && !uhost_req_ready;
            req_held = uhost_req;
            d_stall = tl_d_valid && !tl_d_ready;
            d_held = tl_d;

            if (tl_a_valid && tl_a_ready) begin
                accept_a();
            end
            if (uhost_req_valid && uhost_req_ready) begin
                check_req();
            end
            if (uhost_resp_valid && uhost_resp_ready &&
                uhost_resp.cmd.opcode == UMI_RESP_WRITE) begin
                acked += (int'(uhost_resp.cmd.len) + 1) << uhost_resp.cmd.size;
            end
            if (tl_d_valid && tl_d_ready) begin
                check_d();
            end
        end
    end

endmodule

//--- dv/tl2umi_tb.sv
module tl2umi_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tl2umi_pkg::*;

    localparam int N_TRANS      = 200;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = 40 * N_TRANS + RESET_CYCLES;

    logic        clk;
    logic        nreset;
    chipid_t     chipid;
    logic        tl_a_valid;
    tl_a_t       tl_a;
    logic        tl_a_ready;
    logic        tl_d_valid;
    tl_d_t       tl_d;
    logic        tl_d_ready;
    logic        uhost_req_valid;
    umi_packet_t uhost_req;
    logic        uhost_req_ready;
    logic        uhost_resp_valid;
    umi_packet_t uhost_resp;
    logic        uhost_resp_ready;
    int          errors;
    int          tests;
    logic        drained;

    logic [31:0] lfsr;
    logic [7:0]  dev_mem [64];
    umi_packet_t resp_q [$];

    tl2umi u_tl2umi (.*);

    tl2umi_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic drive_a_beat();
        logic [2:0]  code;
        logic [2:0]  size;
        logic [2:0]  lo;
        logic [52:0] upper;
        int          win;
        int          off;
        int          len;
        code = 3'(rand_bits(3));
        // 6 and 7 fold back onto Get and PutPartialData
        if (code == 3'd6) begin
            code = 3'd4;
        end else if (code == 3'd7) begin
            code = 3'd1;
        end
        size = 3'(rand_bits(2));
        win = 1 << size;
        lo = 3'(rand_bits(3)) & ~3'(win - 1);
        upper = 53'(rand_bits(53));
        off = 0;
        len = win;
        // Partial writes keep a contiguous run of lanes
        if (code == 3'd1) begin
            off = int'(rand_bits(3)) % win;
            len = 1 + int'(rand_bits(3)) % (win - off);
        end
        tl_a = '0;
        tl_a.opcode = tl_a_opcode_e'(code);
        tl_a.size = size;
        tl_a.source = tl_source_t'(rand_bits(5));
        tl_a.address = {upper, lo};
        tl_a.mask = 8'(((1 << len) - 1) << (int'(lo) + off));
        tl_a.data = rand_bits(64);
    endtask

    // UMI device: byte memory, reads unsplit, writes acked in one or two parts
    task automatic device_respond(input umi_packet_t req);
        umi_packet_t rsp;
        int          n;
        int          k;
        int          base;
        n = int'(req.cmd.len) + 1;
        base = int'(req.dstaddr[5:0]);
        rsp = '0;
        rsp.dstaddr = req.srcaddr;
        rsp.cmd.eom = 1'b1;
        if (req.cmd.opcode == UMI_REQ_READ) begin
            rsp.cmd.opcode = UMI_RESP_READ;
            rsp.cmd.len = req.cmd.len;
            for (int i = 0; i < n; i++) begin
                rsp.data[8*i +: 8] = dev_mem[(base + i) % 64];
            end
            resp_q.push_back(rsp);
        end else begin
            for (int i = 0; i < n; i++) begin
                dev_mem[(base + i) % 64] = req.data[8*i +: 8];
            end
            rsp.cmd.opcode = UMI_RESP_WRITE;
            if (n > 1 && rand_bits(1) == 1) begin
                k = 1 + int'(rand_bits(3)) % (n - 1);
                rsp.cmd.eom = 1'b0;
                rsp.cmd.len = byte_count_t'(k - 1);
                resp_q.push_back(rsp);
                rsp.cmd.eom = 1'b1;
                rsp.cmd.len = byte_count_t'(n - k - 1);
                resp_q.push_back(rsp);
            end else if ((n & (n - 1)) == 0) begin
                // Power of two count goes out as one wide word
                rsp.cmd.size = 3'($clog2(n));
                resp_q.push_back(rsp);
            end else begin
                rsp.cmd.len = byte_count_t'(n - 1);
                resp_q.push_back(rsp);
            end
        end
    endtask

    initial begin
        logic        a_fire;
        logic        req_fire;
        logic        resp_fire;
        umi_packet_t req_pkt;
        int          sent;
        int          gap;
        lfsr = 32'heee636fc;
        for (int i = 0; i < 64; i++) begin
            dev_mem[i] = 8'(i * 37 + 11);
        end
        nreset = 1'b0;
        tl_a_valid = 1'b0;
        tl_a = '0;
        tl_d_ready = 1'b0;
        uhost_req_ready = 1'b0;
        uhost_resp_valid = 1'b0;
        uhost_resp = '0;
        chipid = chipid_t'(rand_bits(16));
        sent = 0;
        gap = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        nreset = 1'b1;

        while (!(sent == N_TRANS && tl_a_ready && resp_q.size() == 0)) begin
            @(posedge clk);
            a_fire = tl_a_valid && tl_a_ready;
            req_fire = uhost_req_valid && uhost_req_ready;
            req_pkt = uhost_req;
            resp_fire = uhost_resp_valid && uhost_resp_ready;
            @(negedge clk);
            if (a_fire) begin
                sent++;
                tl_a_valid = 1'b0;
                gap = int'(rand_bits(2));
            end
            if (!tl_a_valid && sent < N_TRANS) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    drive_a_beat();
                    tl_a_valid = 1'b1;
                end
            end
            if (req_fire) begin
                device_respond(req_pkt);
            end
            if (resp_fire) begin
                void'(resp_q.pop_front());
                uhost_resp_valid = 1'b0;
            end
            // Responses come back after a random delay
            if (!uhost_resp_valid && resp_q.size() != 0 && rand_bits(1) == 1) begin
                uhost_resp = resp_q[0];
                uhost_resp_valid = 1'b1;
            end
            uhost_req_ready = (rand_bits(2) != 0);
            tl_d_ready = (rand_bits(2) != 0);
        end
        repeat (4) @(negedge clk);

        if (tests != N_TRANS) begin
            $display("only %0d of %0d transactions completed", tests, N_TRANS);
        end
        if (!drained) begin
            $display("a request or D beat was still expected at the end of the run");
        end
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0 && tests == N_TRANS && drained) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("tests failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/tl2umi_pkg.sv
rtl/tl2umi_mask_convert.sv
rtl/tl2umi_req_fsm.sv
rtl/tl2umi_req_fifo.sv
rtl/tl2umi_resp_fsm.sv
rtl/tl2umi.sv
dv/tl2umi_checker.sv
dv/tl2umi_tb.sv
